/* Makefile */
VERILATOR ?= verilator
TOP       ?= ls_stage_tb
RTL_TOP   ?= ls_stage
FILELIST  ?= ls_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* clint/clint.sv */
`timescale 1ns/1ps
`include "ls_defines.svh"

module clint import ls_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    output logic      timer_irq_o
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [`XLEN-1:0] mtime_q;
    logic [`XLEN-1:0] mtimecmp_q;
    logic [`XLEN-1:0] r_data_q;
    logic [1:0]       r_resp_q;
    logic [1:0]       b_resp_q;
    logic             r_valid_q;
    logic             b_valid_q;
    logic             irq_q;
    logic             wr_fire;
    logic             rd_fire;
    logic             wr_cmp;
    logic             wr_time;

    function automatic logic [`XLEN-1:0] strb_merge(input logic [`XLEN-1:0] old_v,
                                                    input logic [`XLEN-1:0] new_v,
                                                    input logic [7:0]       strb);
        logic [`XLEN-1:0] res;
        res = old_v;
        for (int i = 0; i < 8; i++) begin
            if (strb[i])
                res[i*8 +: 8] = new_v[i*8 +: 8];
        end
        return res;
    endfunction

    // aw and w go in the same cycle, and never while a response is waiting
    assign wr_fire = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
    assign rd_fire = axil_req_i.ar_valid & ~r_valid_q;
    assign wr_cmp  = wr_fire && (axil_req_i.aw_addr[15:0] == `CLINT_MTIMECMP);
    assign wr_time = wr_fire && (axil_req_i.aw_addr[15:0] == `CLINT_MTIME);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
        end else begin
            mtime_q <= wr_time ? strb_merge(mtime_q, axil_req_i.w_data, axil_req_i.w_strb)
                               : mtime_q + 1'b1;
            if (wr_cmp)
                mtimecmp_q <= strb_merge(mtimecmp_q, axil_req_i.w_data, axil_req_i.w_strb);
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (wr_fire)
                b_valid_q <= 1'b1;
            else if (axil_req_i.b_ready)
                b_valid_q <= 1'b0;
            if (rd_fire)
                r_valid_q <= 1'b1;
            else if (axil_req_i.r_ready)
                r_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            b_resp_q <= (wr_cmp || wr_time) ? RESP_OKAY : RESP_SLVERR;
        if (rd_fire) begin
            case (axil_req_i.ar_addr[15:0])
                `CLINT_MTIMECMP: {r_data_q, r_resp_q} <= {mtimecmp_q, RESP_OKAY};
                `CLINT_MTIME:    {r_data_q, r_resp_q} <= {mtime_q, RESP_OKAY};
                default:         {r_data_q, r_resp_q} <= {`XLEN'(0), RESP_SLVERR};
            endcase
        end
    end

    always_comb begin
        axil_rsp_o.ar_ready = ~r_valid_q;
        axil_rsp_o.r_valid  = r_valid_q;
        axil_rsp_o.r_data   = r_data_q;
        axil_rsp_o.r_resp   = r_resp_q;
        axil_rsp_o.aw_ready = ~b_valid_q & axil_req_i.w_valid;
        axil_rsp_o.w_ready  = ~b_valid_q & axil_req_i.aw_valid;
        axil_rsp_o.b_valid  = b_valid_q;
        axil_rsp_o.b_resp   = b_resp_q;
    end

    assign timer_irq_o = irq_q;

    a_r_hold: assert property (@(posedge clk) disable iff (reset_i)
        r_valid_q && !axil_req_i.r_ready |=> r_valid_q && $stable(r_data_q));

endmodule

/* common/ls_defines.svh */
`ifndef LS_DEFINES_SVH
`define LS_DEFINES_SVH

// datapath width of the core
`define XLEN            64

// ***************************************************************************
// opcode fields, instr[6:2]
// ***************************************************************************
`define OP_LOAD         5'b00000
`define OP_STORE        5'b01000
`define OP_SYSTEM       5'b11100

// ***************************************************************************
// machine mode csr addresses
// ***************************************************************************
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MIP         12'h344

// clint register offsets, low 16 address bits
`define CLINT_MTIMECMP  16'h4000
`define CLINT_MTIME     16'hBFF8

`endif

/* common/ls_pkg.sv */
`include "ls_defines.svh"

package ls_pkg;

    // load/store width, same encoding as funct3
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } memop_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_cmd_e;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic             rd_en;
        logic             wr_en;
        logic [`XLEN-1:0] wr_data;     // already replicated across lanes
        logic [7:0]       wr_mask;
        logic [2:0]       size;        // log2 of the access bytes
    } sram_req_t;

    typedef struct packed {
        logic             rd_valid;
        logic             wr_ok;
        logic [`XLEN-1:0] rd_data;
    } sram_rsp_t;

    typedef struct packed {
        logic             ar_valid;
        logic [`XLEN-1:0] ar_addr;
        logic             r_ready;
        logic             aw_valid;
        logic [`XLEN-1:0] aw_addr;
        logic             w_valid;
        logic [`XLEN-1:0] w_data;
        logic [7:0]       w_strb;
        logic             b_ready;
    } axil_req_t;

    typedef struct packed {
        logic             ar_ready;
        logic             r_valid;
        logic [`XLEN-1:0] r_data;
        logic [1:0]       r_resp;
        logic             aw_ready;
        logic             w_ready;
        logic             b_valid;
        logic [1:0]       b_resp;
    } axil_rsp_t;

endpackage

/* csr/csr_file.sv */
`timescale 1ns/1ps
`include "ls_defines.svh"

module csr_file import ls_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [`XLEN-1:0] pc_i,
    input  csr_cmd_e         csr_cmd_i,
    input  logic [11:0]      csr_addr_i,
    input  logic [`XLEN-1:0] csr_wdata_i,
    input  logic             trap_i,
    input  logic             mret_i,
    input  logic             stall_n_i,
    input  logic             timer_irq_i,
    output logic [`XLEN-1:0] csr_data_o,
    output logic [`XLEN-1:0] mtvec_o,
    output logic [`XLEN-1:0] mepc_o,
    output logic             intr_o
);

    localparam int               MIE_BIT       = 3;
    localparam int               MPIE_BIT      = 7;
    localparam int               MTI_BIT       = 7;     // MTIE in mie, MTIP in mip
    localparam logic [`XLEN-1:0] MSTATUS_WMASK = `XLEN'(8'h88);
    localparam logic [`XLEN-1:0] CAUSE_ECALL   = `XLEN'(11);
    localparam logic [`XLEN-1:0] CAUSE_TIMER   = {1'b1, 63'd7};

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mie_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] mscratch_q;
    logic [`XLEN-1:0] mip_w;
    logic [`XLEN-1:0] csr_new;
    logic             entry;
    logic             csr_wr;

    assign mip_w = `XLEN'(timer_irq_i) << MTI_BIT;

    always_comb begin
        case (csr_addr_i)
            `CSR_MSTATUS:  csr_data_o = mstatus_q;
            `CSR_MIE:      csr_data_o = mie_q;
            `CSR_MIP:      csr_data_o = mip_w;
            `CSR_MTVEC:    csr_data_o = mtvec_q;
            `CSR_MEPC:     csr_data_o = mepc_q;
            `CSR_MCAUSE:   csr_data_o = mcause_q;
            `CSR_MSCRATCH: csr_data_o = mscratch_q;
            default:       csr_data_o = '0;
        endcase
    end

    always_comb begin
        case (csr_cmd_i)
            CSR_WRITE: csr_new = csr_wdata_i;
            CSR_SET:   csr_new = csr_data_o | csr_wdata_i;
            CSR_CLEAR: csr_new = csr_data_o & ~csr_wdata_i;
            default:   csr_new = csr_data_o;
        endcase
    end

    assign intr_o = stall_n_i & mstatus_q[MIE_BIT] & mie_q[MTI_BIT] & timer_irq_i;
    assign entry  = intr_o | (stall_n_i & trap_i);
    assign csr_wr = stall_n_i & (csr_cmd_i != CSR_NONE) & ~entry & ~mret_i;

    // ***********************************************************************
    // status and enable
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q <= '0;
            mie_q     <= '0;
        end else if (entry) begin
            mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
            mstatus_q[MIE_BIT]  <= 1'b0;
        end else if (stall_n_i && mret_i) begin
            mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
            mstatus_q[MPIE_BIT] <= 1'b1;
        end else if (csr_wr) begin
            if (csr_addr_i == `CSR_MSTATUS)
                mstatus_q <= csr_new & MSTATUS_WMASK;
            if (csr_addr_i == `CSR_MIE)
                mie_q <= csr_new;
        end
    end

    // ***********************************************************************
    // trap vector, exception pc, cause, scratch
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (entry) begin
            mepc_q   <= pc_i;
            mcause_q <= intr_o ? CAUSE_TIMER : CAUSE_ECALL;   // interrupt wins
        end else if (csr_wr) begin
            case (csr_addr_i)
                `CSR_MTVEC:    mtvec_q    <= csr_new;
                `CSR_MEPC:     mepc_q     <= csr_new;
                `CSR_MCAUSE:   mcause_q   <= csr_new;
                `CSR_MSCRATCH: mscratch_q <= csr_new;
                default:       ;
            endcase
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

    // an instruction leaving through mret cannot also be trapping or interrupted
    a_entry_not_mret: assert property (@(posedge clk) disable iff (reset_i)
        entry |-> !mret_i);

endmodule

/* dv/ls_stage_tb.sv */
`timescale 1ns/1ps
`include "ls_defines.svh"

module ls_stage_tb import ls_pkg::*; ();

    localparam int          TIMEOUT    = 50;
    localparam logic [63:0] CLINT_BASE = 64'h0200_0000;
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] wb_data;
    logic             ld_csr_hazard;
    logic             trap;
    logic             stall_n;
    sram_rsp_t        sram_rsp = '0;
    axil_req_t        clint_req;
    logic [`XLEN-1:0] ls_res;
    logic             ls_busy;
    logic [`XLEN-1:0] csr_data;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic             intr;
    sram_req_t        sram_req;
    axil_rsp_t        clint_rsp;

    logic [7:0]       mem [256];
    logic             rsp_due = 1'b0;
    logic             rsp_rd;
    logic [63:0]      rsp_data;
    int unsigned      wait_left;
    int               cycle_cnt = 0;
    int               checks = 0;
    int               errors = 0;

    ls_stage dut (
        .clk             (clk),
        .reset_i         (reset),
        .pc_i            (pc),
        .instr_i         (instr),
        .alu_res_i       (alu_res),
        .rs2_i           (rs2),
        .wb_data_i       (wb_data),
        .ld_csr_hazard_i (ld_csr_hazard),
        .trap_i          (trap),
        .stall_n_i       (stall_n),
        .sram_rsp_i      (sram_rsp),
        .clint_req_i     (clint_req),
        .ls_res_o        (ls_res),
        .ls_busy_o       (ls_busy),
        .csr_data_o      (csr_data),
        .mtvec_o         (mtvec),
        .mepc_o          (mepc),
        .intr_o          (intr),
        .sram_req_o      (sram_req),
        .clint_rsp_o     (clint_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ***************************************************************************
    // reference model
    // ***************************************************************************
    function automatic logic [7:0] expected_mask(input logic [1:0] size, input logic [2:0] offs);
        int nbytes;
        nbytes = 1 << size;
        return 8'(((1 << nbytes) - 1) << offs);
    endfunction

    function automatic logic [63:0] extend_load(input logic [2:0] funct3, input logic [7:0] addr);
        logic [63:0] raw;
        for (int i = 0; i < 8; i++)
            raw[i*8 +: 8] = mem[addr + 8'(i)];     // bytes past the access size are ignored
        case (funct3)
            3'b000:  return {{56{raw[7]}}, raw[7:0]};
            3'b001:  return {{48{raw[15]}}, raw[15:0]};
            3'b010:  return {{32{raw[31]}}, raw[31:0]};
            3'b100:  return {56'b0, raw[7:0]};
            3'b101:  return {48'b0, raw[15:0]};
            3'b110:  return {32'b0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    function automatic logic [63:0] csr_update(input logic [1:0] cmd, input logic [63:0] old,
                                               input logic [63:0] operand);
        case (cmd)
            2'b01:   return operand;
            2'b10:   return old | operand;
            2'b11:   return old & ~operand;
            default: return old;
        endcase
    endfunction

    // mie sits in bit 3 and mpie in bit 7
    function automatic logic [63:0] mstatus_after(input logic [63:0] old, input logic is_mret);
        logic [63:0] res;
        res = old;
        if (is_mret) begin
            res[3] = old[7];
            res[7] = 1'b1;
        end else begin
            res[7] = old[3];
            res[3] = 1'b0;
        end
        return res;
    endfunction

    function automatic logic [31:0] encode_instr(input logic [6:0] opcode, input logic [2:0] f3,
                                                 input logic [11:0] upper);
        return {upper, 5'd2, f3, 5'd1, opcode};
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_in_time(input int n, input int limit, input string what);
        assert (n < limit) else begin
            errors++;
            $display("%s did not arrive within %0d cycles", what, limit);
        end
    endtask

    // ***************************************************************************
    // sram model, one to four cycles per access
    // ***************************************************************************
    always @(posedge clk) begin
        if (reset) begin
            rsp_due   <= 1'b0;
            wait_left <= $urandom_range(3, 0);
        end else if (rsp_due) begin
            if (sram_req.wr_en) begin
                for (int i = 0; i < 8; i++)
                    if (sram_req.wr_mask[i])
                        mem[{sram_req.addr[7:3], 3'(i)}] = sram_req.wr_data[i*8 +: 8];
            end
            rsp_due   <= 1'b0;
            wait_left <= $urandom_range(3, 0);
        end else if ((sram_req.rd_en || sram_req.wr_en) && wait_left == 0) begin
            rsp_due <= 1'b1;
            rsp_rd  <= sram_req.rd_en;
            for (int i = 0; i < 8; i++)
                rsp_data[i*8 +: 8] <= mem[{sram_req.addr[7:3], 3'(i)}];
        end else if (sram_req.rd_en || sram_req.wr_en) begin
            wait_left <= wait_left - 1;
        end
    end

    always @(negedge clk) begin
        sram_rsp.rd_valid <= rsp_due & rsp_rd;
        sram_rsp.wr_ok    <= rsp_due & ~rsp_rd;
        sram_rsp.rd_data  <= rsp_data;
    end

    // every store request cycle is compared against the driven instruction
    always @(posedge clk) begin : store_check
        logic [7:0]  mask;
        logic [63:0] lanes;
        if (!reset && sram_req.wr_en) begin
            mask = expected_mask(instr[13:12], alu_res[2:0]);
            for (int i = 0; i < 8; i++)
                lanes[i*8 +: 8] = {8{mask[i]}};
            check_eq("store mask", 64'(mask), 64'(sram_req.wr_mask));
            check_eq("store size", 64'($countones(mask)), 64'(1) << sram_req.size);
            check_eq("store data", (rs2 << {alu_res[2:0], 3'b000}) & lanes,
                     sram_req.wr_data & lanes);
        end
    end

    // ***************************************************************************
    // drivers
    // ***************************************************************************
    task automatic mem_access(input logic [31:0] ins, input logic [7:0] addr,
                              input logic [63:0] data, output logic [63:0] res);
        int n;
        @(negedge clk);
        instr   = ins;
        alu_res = 64'(addr);
        rs2     = data;
        n = 0;
        @(posedge clk);
        while (ls_busy && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        check_in_time(n, TIMEOUT, "SRAM response");
        res = ls_res;
        @(posedge clk);                 // instruction still held after completion
        assert (!ls_busy && !sram_req.rd_en && !sram_req.wr_en) else begin
            errors++;
            $display("lsu stayed busy or repeated a finished access");
        end
        @(negedge clk);
        instr = NOP;
    endtask

    task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr, input logic [63:0] val,
                          input logic hazard);
        @(negedge clk);
        instr         = encode_instr(7'b1110011, f3, addr);
        alu_res       = hazard ? ~val : val;
        wb_data       = val;
        ld_csr_hazard = hazard;
        @(negedge clk);
        instr         = NOP;
        ld_csr_hazard = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [63:0] val);
        @(negedge clk);
        instr = encode_instr(7'b1110011, 3'b000, addr);
        @(posedge clk);
        val = csr_data;
    endtask

    task automatic axil_write(input logic [15:0] offs, input logic [63:0] data,
                              output logic [1:0] resp);
        int n;
        @(negedge clk);
        clint_req.aw_valid = 1'b1;
        clint_req.aw_addr  = CLINT_BASE | 64'(offs);
        clint_req.w_valid  = 1'b1;
        clint_req.w_data   = data;
        clint_req.w_strb   = 8'hff;
        n = 0;
        @(posedge clk);
        while (!(clint_rsp.aw_ready && clint_rsp.w_ready) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        check_in_time(n, TIMEOUT, "AXI write handshake");
        @(negedge clk);
        clint_req.aw_valid = 1'b0;
        clint_req.w_valid  = 1'b0;
        clint_req.b_ready  = 1'b1;
        n = 0;
        @(posedge clk);
        while (!clint_rsp.b_valid && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        check_in_time(n, TIMEOUT, "AXI write response");
        resp = clint_rsp.b_resp;
        @(negedge clk);
        clint_req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] offs, output logic [63:0] data,
                             output logic [1:0] resp);
        int n;
        @(negedge clk);
        clint_req.ar_valid = 1'b1;
        clint_req.ar_addr  = CLINT_BASE | 64'(offs);
        n = 0;
        @(posedge clk);
        while (!clint_rsp.ar_ready && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        check_in_time(n, TIMEOUT, "AXI read address handshake");
        @(negedge clk);
        clint_req.ar_valid = 1'b0;
        clint_req.r_ready  = 1'b1;
        n = 0;
        @(posedge clk);
        while (!clint_rsp.r_valid && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        check_in_time(n, TIMEOUT, "AXI read data");
        data = clint_rsp.r_data;
        resp = clint_rsp.r_resp;
        @(negedge clk);
        clint_req.r_ready = 1'b0;
    endtask

    // ***************************************************************************
    // test sequence
    // ***************************************************************************
    initial begin
        logic [63:0] res;
        logic [63:0] exp;
        logic [63:0] val;
        logic [63:0] old;
        logic [63:0] w;
        logic [1:0]  resp;
        logic [2:0]  f3;
        logic [7:0]  addr;
        logic [11:0] csr;
        int          t0;
        int          n;

        void'($urandom(11));
        for (int i = 0; i < 256; i++)
            mem[i] = 8'(i * 73 + 19);
        reset         = 1'b1;
        pc            = '0;
        instr         = NOP;
        alu_res       = '0;
        rs2           = '0;
        wb_data       = '0;
        ld_csr_hazard = 1'b0;
        trap          = 1'b0;
        stall_n       = 1'b1;
        clint_req     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int k = 0; k < 16; k++) begin
            f3   = 3'($urandom_range(3, 0));
            addr = 8'($urandom) & ~8'((1 << f3) - 1);
            mem_access(encode_instr(7'b0100011, f3, 12'h0), addr, {$urandom, $urandom}, res);
            check_eq("store result", 64'(addr), res);
        end

        for (int k = 0; k < 14; k++) begin
            f3   = 3'(k % 7);
            addr = 8'($urandom) & ~8'((1 << f3[1:0]) - 1);
            exp  = extend_load(f3, addr);
            mem_access(encode_instr(7'b0000011, f3, 12'h0), addr, '0, res);
            check_eq($sformatf("load funct3 %0d", f3), exp, res);
        end

        // write, set, clear, then the same through the writeback operand
        for (int c = 0; c < 2; c++) begin
            csr = (c == 0) ? `CSR_MSCRATCH : `CSR_MTVEC;
            for (int k = 0; k < 5; k++) begin
                f3  = 3'(1 + k % 3);
                w   = {$urandom, $urandom};
                exp = csr_update(f3[1:0], old, w);
                csr_op(f3, csr, w, k >= 3);
                csr_read(csr, val);
                check_eq($sformatf("csr %h funct3 %0d", csr, f3), exp, val);
                old = exp;
            end
        end
        check_eq("mtvec output", old, mtvec);

        csr_op(3'b001, `CSR_MSTATUS, 64'h8, 1'b0);
        csr_read(`CSR_MSTATUS, old);
        check_eq("mstatus write", 64'h8, old);
        @(negedge clk);
        pc    = 64'h8000_1234;
        instr = 32'h0000_0073;                  // ecall
        trap  = 1'b1;
        @(negedge clk);
        trap  = 1'b0;
        instr = NOP;
        csr_read(`CSR_MEPC, val);
        check_eq("trap mepc", pc, val);
        check_eq("trap mepc output", pc, mepc);
        csr_read(`CSR_MCAUSE, val);
        check_eq("trap mcause", 64'd11, val);
        exp = mstatus_after(old, 1'b0);
        csr_read(`CSR_MSTATUS, val);
        check_eq("trap mstatus", exp, val);
        @(negedge clk);
        instr = 32'h3020_0073;
        @(negedge clk);
        instr = NOP;
        exp = mstatus_after(exp, 1'b1);
        csr_read(`CSR_MSTATUS, val);
        check_eq("mret mstatus", exp, val);

        w = {1'b1, 31'($urandom), 32'($urandom)};   // far in the future
        axil_write(`CLINT_MTIMECMP, w, resp);
        check_eq("mtimecmp write resp", 64'd0, 64'(resp));
        axil_read(`CLINT_MTIMECMP, val, resp);
        check_eq("mtimecmp readback", w, val);
        w  = 64'($urandom);
        t0 = cycle_cnt;
        axil_write(`CLINT_MTIME, w, resp);
        axil_read(`CLINT_MTIME, val, resp);
        n = cycle_cnt - t0;
        checks++;
        assert (val >= w && val <= w + 64'(n)) else begin
            errors++;
            $display("Error mtime read: expected %h to %h, actual %h", w, w + 64'(n), val);
        end
        axil_read(16'h1000, val, resp);
        check_eq("unmapped read resp", 64'd2, 64'(resp));
        check_eq("unmapped read data", 64'd0, val);

        csr_op(3'b001, `CSR_MIE, 64'h80, 1'b0);
        pc = 64'h8000_2000;
        axil_write(`CLINT_MTIME, 64'd0, resp);
        axil_write(`CLINT_MTIMECMP, 64'd30, resp);
        n = 0;
        @(posedge clk);
        while (!intr && n < 200) begin
            @(posedge clk);
            n++;
        end
        check_in_time(n, 200, "timer interrupt");
        csr_read(`CSR_MCAUSE, val);
        check_eq("interrupt mcause", {1'b1, 63'd7}, val);
        csr_read(`CSR_MEPC, val);
        check_eq("interrupt mepc", pc, val);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* hw/ls_ctr.sv */
`timescale 1ns/1ps
`include "ls_defines.svh"

module ls_ctr import ls_pkg::*; (
    input  logic [31:0]      instr_i,
    input  logic [`XLEN-1:0] rs2_i,
    output logic             rd_en_o,
    output logic             wr_en_o,
    output memop_e           memop_o,
    output logic [`XLEN-1:0] wr_data_o,
    output csr_cmd_e         csr_cmd_o,
    output logic [11:0]      csr_addr_o,
    output logic             mret_o
);

    localparam logic [31:0] MRET_INSTR = 32'h3020_0073;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic       is_system;

    assign opcode    = instr_i[6:2];
    assign funct3    = instr_i[14:12];
    assign is_system = (opcode == `OP_SYSTEM);

    assign rd_en_o    = (opcode == `OP_LOAD);
    assign wr_en_o    = (opcode == `OP_STORE);
    assign memop_o    = memop_e'(funct3);
    assign csr_addr_o = instr_i[31:20];
    assign mret_o     = (instr_i == MRET_INSTR);   // only the exact encoding

    // the sram picks the right lanes with the mask, so every lane carries the value
    always_comb begin
        case (funct3[1:0])
            2'b00:   wr_data_o = {8{rs2_i[7:0]}};
            2'b01:   wr_data_o = {4{rs2_i[15:0]}};
            2'b10:   wr_data_o = {2{rs2_i[31:0]}};
            default: wr_data_o = rs2_i;
        endcase
    end

    // funct3[2] only picks the zimm operand, which comes in on the alu result
    always_comb begin
        csr_cmd_o = CSR_NONE;
        if (is_system) begin
            case (funct3[1:0])
                2'b01:   csr_cmd_o = CSR_WRITE;
                2'b10:   csr_cmd_o = CSR_SET;
                2'b11:   csr_cmd_o = CSR_CLEAR;
                default: csr_cmd_o = CSR_NONE;      // ecall, ebreak, mret
            endcase
        end
    end

endmodule

/* hw/ls_stage.sv */
`timescale 1ns/1ps
`include "ls_defines.svh"

module ls_stage import ls_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [31:0]      instr_i,
    input  logic [`XLEN-1:0] alu_res_i,
    input  logic [`XLEN-1:0] rs2_i,
    input  logic [`XLEN-1:0] wb_data_i,
    input  logic             ld_csr_hazard_i,
    input  logic             trap_i,
    input  logic             stall_n_i,
    input  sram_rsp_t        sram_rsp_i,
    input  axil_req_t        clint_req_i,
    output logic [`XLEN-1:0] ls_res_o,
    output logic             ls_busy_o,
    output logic [`XLEN-1:0] csr_data_o,
    output logic [`XLEN-1:0] mtvec_o,
    output logic [`XLEN-1:0] mepc_o,
    output logic             intr_o,
    output sram_req_t        sram_req_o,
    output axil_rsp_t        clint_rsp_o
);

    logic             rd_en;
    logic             wr_en;
    memop_e           memop;
    logic [`XLEN-1:0] wr_data;
    csr_cmd_e         csr_cmd;
    logic [11:0]      csr_addr;
    logic             mret;
    logic [`XLEN-1:0] csr_wdata;
    logic             timer_irq;

    ls_ctr u_ls_ctr (
        .instr_i    (instr_i),
        .rs2_i      (rs2_i),
        .rd_en_o    (rd_en),
        .wr_en_o    (wr_en),
        .memop_o    (memop),
        .wr_data_o  (wr_data),
        .csr_cmd_o  (csr_cmd),
        .csr_addr_o (csr_addr),
        .mret_o     (mret)
    );

    lsu u_lsu (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd_en_i    (rd_en),
        .wr_en_i    (wr_en),
        .memop_i    (memop),
        .wr_data_i  (wr_data),
        .addr_i     (alu_res_i),
        .sram_rsp_i (sram_rsp_i),
        .sram_req_o (sram_req_o),
        .ls_res_o   (ls_res_o),
        .ls_busy_o  (ls_busy_o)
    );

    // a csr op right behind a load takes the loaded value from writeback
    assign csr_wdata = ld_csr_hazard_i ? wb_data_i : alu_res_i;

    csr_file u_csr_file (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .csr_cmd_i   (csr_cmd),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .trap_i      (trap_i),
        .mret_i      (mret),
        .stall_n_i   (stall_n_i),
        .timer_irq_i (timer_irq),
        .csr_data_o  (csr_data_o),
        .mtvec_o     (mtvec_o),
        .mepc_o      (mepc_o),
        .intr_o      (intr_o)
    );

    clint u_clint (
        .clk         (clk),
        .reset_i     (reset_i),
        .axil_req_i  (clint_req_i),
        .axil_rsp_o  (clint_rsp_o),
        .timer_irq_o (timer_irq)
    );

endmodule

/* hw/lsu.sv */
`timescale 1ns/1ps
`include "ls_defines.svh"

module lsu import ls_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             rd_en_i,
    input  logic             wr_en_i,
    input  memop_e           memop_i,
    input  logic [`XLEN-1:0] wr_data_i,
    input  logic [`XLEN-1:0] addr_i,
    input  sram_rsp_t        sram_rsp_i,
    output sram_req_t        sram_req_o,
    output logic [`XLEN-1:0] ls_res_o,
    output logic             ls_busy_o
);

    sram_req_t        req_c;
    sram_req_t        last_req_q;
    logic             done_q;
    logic             repeat_acc;
    logic             complete;
    logic [7:0]       size_mask;
    logic [`XLEN-1:0] rdata_q;
    logic [`XLEN-1:0] rd_raw;
    logic [`XLEN-1:0] rd_shift;
    logic [`XLEN-1:0] ld_data;

    // ***********************************************************************
    // request
    // ***********************************************************************
    always_comb begin
        case (memop_i[1:0])
            2'b00:   size_mask = 8'h01;
            2'b01:   size_mask = 8'h03;
            2'b10:   size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    always_comb begin
        req_c.addr    = addr_i;
        req_c.rd_en   = rd_en_i;
        req_c.wr_en   = wr_en_i;
        req_c.wr_data = wr_data_i;
        req_c.wr_mask = size_mask << addr_i[2:0];
        req_c.size    = {1'b0, memop_i[1:0]};
    end

    // same request as the one just finished means the pipeline is still stalled on it
    assign repeat_acc = done_q && (req_c == last_req_q);

    always_comb begin
        sram_req_o       = req_c;
        sram_req_o.rd_en = rd_en_i & ~repeat_acc;
        sram_req_o.wr_en = wr_en_i & ~repeat_acc;
    end

    assign complete  = (sram_req_o.rd_en & sram_rsp_i.rd_valid) |
                       (sram_req_o.wr_en & sram_rsp_i.wr_ok);
    assign ls_busy_o = (sram_req_o.rd_en | sram_req_o.wr_en) & ~complete;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= complete | repeat_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            last_req_q <= req_c;
            rdata_q    <= sram_rsp_i.rd_data;
        end
    end

    // ***********************************************************************
    // load data alignment and extension
    // ***********************************************************************
    assign rd_raw   = repeat_acc ? rdata_q : sram_rsp_i.rd_data;
    assign rd_shift = rd_raw >> {addr_i[2:0], 3'b000};

    always_comb begin
        case (memop_i)
            MEM_B:   ld_data = {{56{rd_shift[7]}}, rd_shift[7:0]};
            MEM_H:   ld_data = {{48{rd_shift[15]}}, rd_shift[15:0]};
            MEM_W:   ld_data = {{32{rd_shift[31]}}, rd_shift[31:0]};
            MEM_BU:  ld_data = {56'b0, rd_shift[7:0]};
            MEM_HU:  ld_data = {48'b0, rd_shift[15:0]};
            MEM_WU:  ld_data = {32'b0, rd_shift[31:0]};
            default: ld_data = rd_shift;            // MEM_D
        endcase
    end

    assign ls_res_o = rd_en_i ? ld_data : addr_i;   // non loads pass the alu result

    // decode must never mark one instruction as both load and store
    a_no_rd_wr: assert property (@(posedge clk) disable iff (reset_i)
        !(sram_req_o.rd_en && sram_req_o.wr_en));

endmodule

/* ls_stage.f */
+incdir+common
common/ls_pkg.sv
hw/ls_ctr.sv
hw/lsu.sv
csr/csr_file.sv
clint/clint.sv
hw/ls_stage.sv
dv/ls_stage_tb.sv
